/* Bender.yml */
package:
  name: pipeline_core

sources:
  - logic/cpuPkg.sv
  - logic/decodeControl.sv
  - logic/registerFile.sv
  - logic/forwardingUnit.sv
  - logic/aluUnit.sv
  - logic/pipelineCore.sv
  - target: test
    files:
      - sim/pipelineCoreTb.sv

/* build.f */
logic/cpuPkg.sv
logic/decodeControl.sv
logic/registerFile.sv
logic/forwardingUnit.sv
logic/aluUnit.sv
logic/pipelineCore.sv
sim/pipelineCoreTb.sv

/* logic/aluUnit.sv */
module aluUnit #(
	parameter int DataWidth = 32
) (
	input  cpuPkg::aluOpT        aluOp,
	input  logic [DataWidth-1:0] opA,
	input  logic [DataWidth-1:0] opB,
	output logic [DataWidth-1:0] result
);

	// signed compare for slt
	logic lessThan;

	assign lessThan = $signed(opA) < $signed(opB);

	always_comb begin
		case (aluOp)
			// add and sub wrap at the data width
			cpuPkg::opAdd: result = opA + opB;
			cpuPkg::opSub: result = opA - opB;
			// bitwise ops
			cpuPkg::opAnd: result = opA & opB;
			cpuPkg::opOr:  result = opA | opB;
			cpuPkg::opXor: result = opA ^ opB;
			// one or zero
			cpuPkg::opSlt: result = DataWidth'(lessThan);
			// spare codes
			default:       result = '0;
		endcase
	end

endmodule

/* logic/cpuPkg.sv */
package cpuPkg;

	// register number, 32 architectural registers
	typedef logic [4:0] regIdxT;

	// alu operations, three bits leave room for two more
	typedef enum logic [2:0] {
		opAdd = 3'd0,
		opSub = 3'd1,
		opAnd = 3'd2,
		opOr  = 3'd3,
		opXor = 3'd4,
		opSlt = 3'd5
	} aluOpT;

	// control bits carried down the pipe with the instruction
	typedef struct packed {
		logic  regWrite;
		logic  useImm;
		logic  zeroExtImm;
		aluOpT aluOp;
	} ctrlT;

	// operand source select, same codes as the classic mips forwarding unit
	typedef enum logic [1:0] {
		fwdNone   = 2'b00,
		fwdMemWb  = 2'b01,
		fwdExeMem = 2'b10
	} fwdSelT;

	// source registers held in id/exe
	typedef struct packed {
		regIdxT rs;
		regIdxT rt;
	} srcRegsT;

	// destination of a later stage, as seen by forwarding
	typedef struct packed {
		regIdxT rd;
		logic   regWrite;
	} stageDestT;

	// opcodes
	localparam logic [5:0] opcRtype = 6'h00;
	localparam logic [5:0] opcAddi  = 6'h08;
	localparam logic [5:0] opcAndi  = 6'h0c;
	localparam logic [5:0] opcOri   = 6'h0d;

	// r-type funct codes
	localparam logic [5:0] fnAdd = 6'h20;
	localparam logic [5:0] fnSub = 6'h22;
	localparam logic [5:0] fnAnd = 6'h24;
	localparam logic [5:0] fnOr  = 6'h25;
	localparam logic [5:0] fnXor = 6'h26;
	localparam logic [5:0] fnSlt = 6'h2a;

endpackage

/* logic/decodeControl.sv */
module decodeControl (
	input  logic [31:0]    instr,
	output cpuPkg::regIdxT rs,
	output cpuPkg::regIdxT rt,
	output cpuPkg::regIdxT rd,
	output logic [15:0]    imm16,
	output cpuPkg::ctrlT   ctrl
);

	// instruction fields
	logic [5:0] opcode;
	logic [5:0] funct;

	assign opcode = instr[31:26];
	assign funct  = instr[5:0];

	// source fields sit at the same place for r and i type
	assign rs    = instr[25:21];
	assign rt    = instr[20:16];
	assign imm16 = instr[15:0];

	always_comb begin
		// start as a nop, nothing written
		ctrl = '0;
		// r-type destination field
		rd = instr[15:11];
		case (opcode)
			cpuPkg::opcRtype: begin
				ctrl.regWrite = 1'b1;
				case (funct)
					cpuPkg::fnAdd: ctrl.aluOp = cpuPkg::opAdd;
					cpuPkg::fnSub: ctrl.aluOp = cpuPkg::opSub;
					cpuPkg::fnAnd: ctrl.aluOp = cpuPkg::opAnd;
					cpuPkg::fnOr:  ctrl.aluOp = cpuPkg::opOr;
					cpuPkg::fnXor: ctrl.aluOp = cpuPkg::opXor;
					cpuPkg::fnSlt: ctrl.aluOp = cpuPkg::opSlt;
					// unknown funct drops the write
					default:       ctrl.regWrite = 1'b0;
				endcase
			end
			cpuPkg::opcAddi: begin
				// i-type writes the rt field
				rd = instr[20:16];
				ctrl.regWrite = 1'b1;
				ctrl.useImm = 1'b1;
				ctrl.aluOp = cpuPkg::opAdd;
			end
			cpuPkg::opcAndi: begin
				rd = instr[20:16];
				ctrl.regWrite = 1'b1;
				ctrl.useImm = 1'b1;
				// logical immediates are zero extended
				ctrl.zeroExtImm = 1'b1;
				ctrl.aluOp = cpuPkg::opAnd;
			end
			cpuPkg::opcOri: begin
				rd = instr[20:16];
				ctrl.regWrite = 1'b1;
				ctrl.useImm = 1'b1;
				ctrl.zeroExtImm = 1'b1;
				ctrl.aluOp = cpuPkg::opOr;
			end
			default: begin
				// unsupported opcode, stays a nop
				ctrl.regWrite = 1'b0;
			end
		endcase
	end

endmodule

/* logic/forwardingUnit.sv */
module forwardingUnit (
	input  cpuPkg::srcRegsT   srcRegs,
	input  cpuPkg::stageDestT exeMemDest,
	input  cpuPkg::stageDestT memWbDest,
	output cpuPkg::fwdSelT    fwdOp1,
	output cpuPkg::fwdSelT    fwdOp2
);

	// source select for one operand
	function automatic cpuPkg::fwdSelT pickSource(
		input cpuPkg::regIdxT    src,
		input cpuPkg::stageDestT exeMem,
		input cpuPkg::stageDestT memWb
	);
		// newest result first, exe/mem beats mem/wb
		if (exeMem.regWrite && (exeMem.rd != '0) && (exeMem.rd == src)) begin
			return cpuPkg::fwdExeMem;
		end
		// older result still in flight
		if (memWb.regWrite && (memWb.rd != '0) && (memWb.rd == src)) begin
			return cpuPkg::fwdMemWb;
		end
		// register file value is current
		return cpuPkg::fwdNone;
	endfunction

	// rs feeds operand 1
	assign fwdOp1 = pickSource(srcRegs.rs, exeMemDest, memWbDest);
	// rt feeds operand 2, each with its own select
	assign fwdOp2 = pickSource(srcRegs.rt, exeMemDest, memWbDest);

endmodule

/* logic/pipelineCore.sv */
module pipelineCore #(
	parameter int DataWidth = 32
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 instrValid,
	input  logic [31:0]          instr,
	output logic                 wbValid,
	output cpuPkg::regIdxT       wbRd,
	output logic [DataWidth-1:0] wbData
);

	// decode outputs
	cpuPkg::regIdxT decRs;
	cpuPkg::regIdxT decRt;
	cpuPkg::regIdxT decRd;
	logic [15:0] decImm16;
	cpuPkg::ctrlT decCtrl;
	logic [DataWidth-1:0] decImmExt;

	// register file read data
	logic [DataWidth-1:0] rfDataA;
	logic [DataWidth-1:0] rfDataB;

	// id/exe stage
	cpuPkg::ctrlT idExeCtrl;
	cpuPkg::srcRegsT idExeSrc;
	cpuPkg::regIdxT idExeRd;
	logic [DataWidth-1:0] idExeA;
	logic [DataWidth-1:0] idExeB;
	logic [DataWidth-1:0] idExeImm;

	// exe/mem and mem/wb stages
	cpuPkg::stageDestT exeMemDest;
	logic [DataWidth-1:0] exeMemData;
	cpuPkg::stageDestT memWbDest;
	logic [DataWidth-1:0] memWbData;

	// execute stage
	cpuPkg::fwdSelT fwdOp1;
	cpuPkg::fwdSelT fwdOp2;
	logic [DataWidth-1:0] aluOpA;
	logic [DataWidth-1:0] aluOpB;
	logic [DataWidth-1:0] aluResult;

	decodeControl decodeControl_i (
		.instr(instr),
		.rs(decRs),
		.rt(decRt),
		.rd(decRd),
		.imm16(decImm16),
		.ctrl(decCtrl)
	);

	// write port driven from mem/wb
	registerFile #(
		.DataWidth(DataWidth)
	) registerFile_i (
		.clk(clk),
		.reset(reset),
		.rdAddrA(decRs),
		.rdAddrB(decRt),
		.rdDataA(rfDataA),
		.rdDataB(rfDataB),
		.wrEn(wbValid),
		.wrAddr(memWbDest.rd),
		.wrData(memWbData)
	);

	// immediate extension, sign or zero
	assign decImmExt = decCtrl.zeroExtImm ? DataWidth'(decImm16) : DataWidth'($signed(decImm16));

	// id/exe control, a bubble clears regWrite
	always_ff @(posedge clk) begin
		if (reset) begin
			idExeCtrl <= '0;
		end else begin
			idExeCtrl <= decCtrl;
			idExeCtrl.regWrite <= instrValid && decCtrl.regWrite;
		end
	end

	// id/exe payload, loaded only with a valid instruction
	always_ff @(posedge clk) begin
		if (instrValid) begin
			idExeSrc <= '{rs: decRs, rt: decRt};
			idExeRd <= decRd;
			idExeA <= rfDataA;
			idExeB <= rfDataB;
			idExeImm <= decImmExt;
		end
	end

	forwardingUnit forwardingUnit_i (
		.srcRegs(idExeSrc),
		.exeMemDest(exeMemDest),
		.memWbDest(memWbDest),
		.fwdOp1(fwdOp1),
		.fwdOp2(fwdOp2)
	);

	// operand mux shared by both alu inputs
	function automatic logic [DataWidth-1:0] fwdMux(
		input cpuPkg::fwdSelT       sel,
		input logic [DataWidth-1:0] regVal,
		input logic [DataWidth-1:0] exeMemVal,
		input logic [DataWidth-1:0] memWbVal
	);
		case (sel)
			cpuPkg::fwdExeMem: return exeMemVal;
			cpuPkg::fwdMemWb:  return memWbVal;
			default:           return regVal;
		endcase
	endfunction

	assign aluOpA = fwdMux(fwdOp1, idExeA, exeMemData, memWbData);
	// immediate wins over any forwarded rt
	assign aluOpB = idExeCtrl.useImm ? idExeImm : fwdMux(fwdOp2, idExeB, exeMemData, memWbData);

	aluUnit #(
		.DataWidth(DataWidth)
	) aluUnit_i (
		.aluOp(idExeCtrl.aluOp),
		.opA(aluOpA),
		.opB(aluOpB),
		.result(aluResult)
	);

	// exe/mem and mem/wb destinations
	always_ff @(posedge clk) begin
		if (reset) begin
			exeMemDest <= '0;
			memWbDest <= '0;
		end else begin
			exeMemDest <= '{rd: idExeRd, regWrite: idExeCtrl.regWrite};
			memWbDest <= exeMemDest;
		end
	end

	// result data moves with its destination
	always_ff @(posedge clk) begin
		exeMemData <= aluResult;
		memWbData <= exeMemData;
	end

	// writeback, r0 targets are dropped here
	assign wbValid = memWbDest.regWrite && (memWbDest.rd != '0);
	assign wbRd = memWbDest.rd;
	assign wbData = memWbData;

endmodule

/* logic/registerFile.sv */
module registerFile #(
	parameter int DataWidth = 32
) (
	input  logic                 clk,
	input  logic                 reset,
	input  cpuPkg::regIdxT       rdAddrA,
	input  cpuPkg::regIdxT       rdAddrB,
	output logic [DataWidth-1:0] rdDataA,
	output logic [DataWidth-1:0] rdDataB,
	input  logic                 wrEn,
	input  cpuPkg::regIdxT       wrAddr,
	input  logic [DataWidth-1:0] wrData
);

	// register array
	logic [DataWidth-1:0] regs [32];

	// write port, r0 never written
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn && (wrAddr != '0)) begin
			regs[wrAddr] <= wrData;
		end
	end

	// one read port with r0 and write-through handling
	function automatic logic [DataWidth-1:0] readPort(input cpuPkg::regIdxT addr);
		if (addr == '0) begin
			return '0;
		end
		// same-cycle write goes straight to the reader
		if (wrEn && (wrAddr == addr)) begin
			return wrData;
		end
		return regs[addr];
	endfunction

	always_comb begin
		rdDataA = readPort(rdAddrA);
		rdDataB = readPort(rdAddrB);
	end

endmodule

/* sim/pipelineCoreTb.sv */
module pipelineCoreTb;

	// one expected writeback, due is the cycle it must show
	typedef struct packed {
		logic [4:0]  rd;
		logic [31:0] data;
		int          due;
	} wbExpT;

	logic           clk;
	logic           reset;
	logic           instrValid;
	logic [31:0]    instr;
	logic           wbValid;
	cpuPkg::regIdxT wbRd;
	logic [31:0]    wbData;

	// reference registers and writebacks still in flight
	logic [31:0] model [32];
	wbExpT       expQ [$];
	int          cycleCount;
	int          mismatches;
	int          otherErrors;

	pipelineCore #(
		.DataWidth(32)
	) pipelineCore_i (
		.clk(clk),
		.reset(reset),
		.instrValid(instrValid),
		.instr(instr),
		.wbValid(wbValid),
		.wbRd(wbRd),
		.wbData(wbData)
	);

	always #50 clk = ~clk;

	// edges seen so far
	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
	end

	task automatic checkValue(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			mismatches++;
			$display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	// sampled mid-cycle, oldest expected entry first
	always @(negedge clk) begin : monitor
		wbExpT head;
		if (wbValid === 1'b1) begin
			if (expQ.size() == 0) begin
				otherErrors++;
				$display("unexpected writeback to r%0d at %0t", wbRd, $time);
			end else begin
				head = expQ.pop_front();
				checkValue("writeback cycle", cycleCount, head.due);
				checkValue("writeback rd", wbRd, head.rd);
				checkValue("writeback data", wbData, head.data);
			end
		end else if (expQ.size() != 0 && expQ[0].due <= cycleCount) begin
			head = expQ.pop_front();
			otherErrors++;
			$display("writeback to r%0d missing at %0t", head.rd, $time);
		end
	end

	// instruction encoders
	function automatic logic [31:0] rType(input logic [5:0] fn, input logic [4:0] rd,
			input logic [4:0] rs, input logic [4:0] rt);
		return {6'h00, rs, rt, rd, 5'h00, fn};
	endfunction

	function automatic logic [31:0] iType(input logic [5:0] opc, input logic [4:0] rt,
			input logic [4:0] rs, input logic [15:0] imm);
		return {opc, rs, rt, imm};
	endfunction

	// isa rules in program order, queues the writeback three cycles out
	task automatic issue(input logic [31:0] word);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		logic [4:0]  dest;
		logic        writes;
		a = model[word[25:21]];
		b = model[word[20:16]];
		dest = word[20:16];
		writes = 1'b1;
		res = '0;
		case (word[31:26])
			6'h00: begin
				dest = word[15:11];
				case (word[5:0])
					6'h20: res = a + b;
					6'h22: res = a - b;
					6'h24: res = a & b;
					6'h25: res = a | b;
					6'h26: res = a ^ b;
					6'h2a: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default: writes = 1'b0;
				endcase
			end
			// addi sign extends, andi and ori zero extend
			6'h08: res = a + {{16{word[15]}}, word[15:0]};
			6'h0c: res = a & {16'h0000, word[15:0]};
			6'h0d: res = a | {16'h0000, word[15:0]};
			default: writes = 1'b0;
		endcase
		if (writes && dest != 5'd0) begin
			model[dest] = res;
			expQ.push_back('{rd: dest, data: res, due: cycleCount + 3});
		end
		instr = word;
		instrValid = 1'b1;
		@(posedge clk);
		#10;
	endtask

	task automatic idle(input int cycles);
		instrValid = 1'b0;
		repeat (cycles) begin
			@(posedge clk);
			#10;
		end
	endtask

	task automatic endRun();
		$display("errors: %0d mismatches, %0d other", mismatches, otherErrors);
		if (mismatches == 0 && otherErrors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	endtask

	// let the pipe empty, bounded
	task automatic waitDrain();
		int waited;
		waited = 0;
		instrValid = 1'b0;
		while (expQ.size() != 0 && waited < 10) begin
			@(posedge clk);
			#10;
			waited++;
		end
		if (expQ.size() != 0) begin
			otherErrors++;
			$display("pipeline did not drain, %0d writebacks pending", expQ.size());
			endRun();
		end else begin
			idle(2);
		end
	endtask

	task automatic resetState();
		for (int i = 0; i < 32; i++) begin
			model[i] = '0;
		end
		reset = 1'b1;
		repeat (8) begin
			@(posedge clk);
			#10;
			checkValue("wbValid in reset", wbValid, 1'b0);
		end
		reset = 1'b0;
		idle(3);
		// or rY, r0, rY reads every register back
		for (int r = 0; r < 32; r++) begin
			issue(rType(6'h25, 5'(r), 0, 5'(r)));
		end
		waitDrain();
	endtask

	task automatic aluOps();
		logic [5:0] fns [6] = '{6'h20, 6'h22, 6'h24, 6'h25, 6'h26, 6'h2a};
		issue(iType(6'h08, 1, 0, 16'd100));
		idle(3);
		issue(iType(6'h0d, 2, 0, 16'h0f0f));
		idle(3);
		// r3 = -5
		issue(iType(6'h08, 3, 0, 16'hfffb));
		idle(3);
		for (int k = 0; k < 6; k++) begin
			issue(rType(fns[k], 5'(4 + k), 1, 3));
			idle(3);
			issue(rType(fns[k], 5'(10 + k), 2, 1));
			idle(3);
		end
		// negative slt, andi
		issue(rType(6'h2a, 16, 3, 1));
		idle(3);
		issue(iType(6'h0c, 17, 3, 16'h00ff));
		waitDrain();
	endtask

	task automatic forwardDistanceOne();
		issue(iType(6'h08, 1, 0, 16'd7));
		issue(rType(6'h20, 2, 1, 0));
		issue(rType(6'h22, 3, 0, 2));
		issue(rType(6'h20, 4, 3, 3));
		waitDrain();
	endtask

	task automatic forwardDistanceTwoAndPriority();
		issue(iType(6'h08, 6, 0, 16'd11));
		issue(iType(6'h08, 7, 0, 16'd1));
		issue(rType(6'h22, 8, 6, 0));
		issue(rType(6'h26, 9, 0, 7));
		idle(3);
		// same target twice, newer must win
		issue(iType(6'h08, 10, 0, 16'd1));
		issue(iType(6'h08, 10, 0, 16'd2));
		issue(rType(6'h20, 11, 10, 10));
		waitDrain();
	endtask

	task automatic bypassAndZeroReg();
		issue(iType(6'h08, 12, 0, 16'h0055));
		idle(2);
		issue(rType(6'h25, 13, 12, 0));
		idle(2);
		issue(rType(6'h20, 14, 0, 13));
		// r0 writes give no writeback
		issue(iType(6'h08, 0, 12, 16'd5));
		issue(rType(6'h20, 0, 12, 12));
		issue(rType(6'h20, 15, 0, 0));
		idle(2);
		issue(rType(6'h25, 16, 0, 0));
		waitDrain();
	endtask

	task automatic randomStream();
		logic [5:0] fns [6] = '{6'h20, 6'h22, 6'h24, 6'h25, 6'h26, 6'h2a};
		logic [31:0] word;
		int kind;
		for (int n = 0; n < 300; n++) begin
			kind = $urandom % 10;
			// registers 0 to 7 only, dense hazards
			case (kind)
				6: word = iType(6'h08, 5'($urandom % 8), 5'($urandom % 8), 16'($urandom));
				7: word = iType(6'h0c, 5'($urandom % 8), 5'($urandom % 8), 16'($urandom));
				8: word = iType(6'h0d, 5'($urandom % 8), 5'($urandom % 8), 16'($urandom));
				9: word = ($urandom % 2) ? rType(6'h3f, 5'($urandom % 8), 1, 2)
						: {6'h3f, 26'($urandom)};
				default: word = rType(fns[kind], 5'($urandom % 8), 5'($urandom % 8),
						5'($urandom % 8));
			endcase
			issue(word);
			if ($urandom % 4 == 0) begin
				idle($urandom % 3);
			end
		end
		waitDrain();
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		instrValid = 1'b0;
		instr = '0;
		cycleCount = 0;
		mismatches = 0;
		otherErrors = 0;
		void'($urandom(98));
		resetState();
		aluOps();
		forwardDistanceOne();
		forwardDistanceTwoAndPriority();
		bypassAndZeroReg();
		randomStream();
		endRun();
	end

endmodule
